//--- build.f
source/cpu_alu_pkg.sv
source/cpu_isa_pkg.sv
source/program_sequencer.sv
source/alu_datapath.sv
source/target_writeback.sv
source/cpu_top.sv
verif/cpu_properties.sv
verif/cpu_tb.sv

//--- Makefile
# Verilator build and run for the microcoded CPU testbench

SRCS := $(wildcard source/*.sv) $(wildcard verif/*.sv)

obj_dir/Vcpu_tb: build.f $(SRCS)
	verilator --binary --timing --assert --top-module cpu_tb -f build.f -o Vcpu_tb

.PHONY: all run clean

all: run

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/cpu_tb.sv
// CPU random program testbench
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int NUM_TESTS = 12;
    localparam int PROLOGUE  = 10;

    logic                CPU;
    logic                _RESET_SWITCH;
    logic                prog_we;
    logic [7:0]          prog_addr;
    cpu_isa_pkg::instr_t prog_data;
    logic                uart_valid;
    cpu_alu_pkg::word_t  uart_data;
    logic                halted;
    cpu_alu_pkg::word_t  halt_code;

    logic [31:0]         lfsr_state;
    cpu_isa_pkg::instr_t prog [64];
    int                  prog_len;
    cpu_alu_pkg::word_t  exp_uart [$];
    cpu_alu_pkg::word_t  got_uart [$];
    cpu_alu_pkg::word_t  exp_halt;
    int                  errors;
    int                  tests_run;
    int                  tests_failed;
    logic                test_bad;
    logic                timed_out;

    cpu_top DUT (
        .CPU(CPU), ._RESET_SWITCH(_RESET_SWITCH),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .uart_valid(uart_valid), .uart_data(uart_data),
        .halted(halted), .halt_code(halt_code)
    );

    always #5 CPU = ~CPU;

    ////////////////////////////////////////
    // random numbers
    ////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    ////////////////////////////////////////
    // program builder
    ////////////////////////////////////////

    function automatic cpu_isa_pkg::instr_t make_instr(input int op, input int targ,
            input int adev, input int bdev, input int cond, input logic sf,
            input logic inv, input logic dir, input int hi, input int lo);
        cpu_isa_pkg::instr_t w;
        w = '0;
        w.alu_op      = cpu_alu_pkg::alu_op_e'(op[4:0]);
        w.targ_dev    = cpu_isa_pkg::targ_dev_e'(targ[4:0]);
        w.adev        = cpu_isa_pkg::adev_e'(adev[3:0]);
        w.bdev        = cpu_isa_pkg::bdev_e'(bdev[3:0]);
        w.condition   = cpu_isa_pkg::cond_e'(cond[3:0]);
        w.set_flags   = sf;
        w.cond_inv    = inv;
        w.addr_direct = dir;
        w.operand     = {hi[7:0], lo[7:0]};
        return w;
    endfunction

    // targets a random ALU word may write
    function automatic int pick_target(input int k);
        int codes [8] = '{0, 1, 2, 3, 7, 6, 5, 11};
        return codes[k];
    endfunction

    task automatic build_program();
        int kind;
        int dir;
        int last;
        prog_len = 20 + rand_bits(6) % 41;
        last = prog_len - 1;
        // registers, MAR and RAM bytes 0..3 get defined values first
        for (int k = 0; k < 4; k++) begin
            prog[k] = make_instr(1, k, 4, 4, 0, 0, 0, 0, rand_bits(8), rand_bits(8));
        end
        prog[4] = make_instr(1, 4, 4, 4, 0, 0, 0, 0, 0, rand_bits(2));
        prog[5] = make_instr(1, 5, 4, 4, 0, 0, 0, 0, 0, rand_bits(8));
        for (int k = 0; k < 4; k++) begin
            prog[6+k] = make_instr(8, 6, k, 4, 0, 0, 0, 1, rand_bits(8), k);
        end
        for (int i = PROLOGUE; i < last; i++) begin
            kind = rand_bits(4);
            if (kind < 10) begin
                dir = rand_bits(1);
                prog[i] = make_instr(rand_bits(4), pick_target(rand_bits(3)),
                    rand_bits(3) % 5, rand_bits(3), rand_bits(4) % 9, rand_bits(1),
                    rand_bits(1), dir, rand_bits(8), dir ? rand_bits(2) : rand_bits(8));
            end else if (kind < 12) begin
                prog[i] = make_instr(1, 4, 4, 4, rand_bits(4) % 9, 0, rand_bits(1), 0,
                    0, rand_bits(2));
            end else if (kind < 14) begin
                // forward jump no further than the halt
                prog[i] = make_instr(1, 9, 4, 4, rand_bits(4) % 9, 0, rand_bits(1), 0,
                    0, i + 1 + rand_bits(6) % (last - i));
            end else if (kind == 14) begin
                prog[i] = make_instr(10, 8, 4, 4, 0, 0, 0, 0, 0, 0);
            end else begin
                prog[i] = make_instr(0, 7, rand_bits(2), 4, 0, 0, 0, 0, 0, 0);
            end
        end
        prog[last] = make_instr(3, 10, rand_bits(2), 4, 0, 0, 0, 0, 0, rand_bits(8));
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    task automatic run_model();
        cpu_alu_pkg::word_t  r [4];
        cpu_alu_pkg::word_t  ram [64];
        cpu_alu_pkg::word_t  marlo;
        cpu_alu_pkg::word_t  marhi;
        cpu_alu_pkg::word_t  a;
        cpu_alu_pkg::word_t  b;
        cpu_alu_pkg::word_t  res;
        cpu_alu_pkg::flags_t fl;
        cpu_alu_pkg::flags_t nf;
        cpu_isa_pkg::instr_t w;
        int   pc;
        int   tot;
        int   stot;
        int   addr;
        logic hit;
        logic done;
        fl = '0;
        marlo = '0;
        marhi = '0;
        pc = 0;
        done = 1'b0;
        exp_uart.delete();
        while (!done && pc < prog_len) begin
            w = prog[pc];
            pc++;
            a = (int'(w.adev) < 4) ? r[int'(w.adev)] : 8'h00;
            addr = w.addr_direct ? int'(w.operand[5:0]) : int'(marlo[5:0]);
            case (int'(w.bdev))
                0, 1, 2, 3: b = r[int'(w.bdev)];
                4: b = w.operand[7:0];
                5: b = ram[addr];
                6: b = marlo;
                7: b = marhi;
                default: b = 8'h00;
            endcase
            nf = '0;
            tot = -1;
            case (int'(w.alu_op))
                0: res = a;
                1: res = b;
                2: begin
                    tot = int'(b) + 1;
                    stot = int'($signed(b)) + 1;
                end
                3: begin
                    tot = int'(a) + int'(b);
                    stot = int'($signed(a)) + int'($signed(b));
                end
                4: begin
                    tot = int'(a) + int'(b) + int'(fl.c);
                    stot = int'($signed(a)) + int'($signed(b)) + int'(fl.c);
                end
                5: begin
                    // carry means no borrow
                    tot = int'(a) - int'(b) + 256;
                    stot = int'($signed(a)) - int'($signed(b));
                end
                6: res = a & b;
                7: res = a | b;
                8: res = a ^ b;
                9: res = ~b;
                default: res = 8'h00;
            endcase
            if (tot >= 0) begin
                res = tot[7:0];
                nf.c = tot > 255;
                nf.o = stot > 127 || stot < -128;
            end
            nf.z = res == 0;
            nf.n = res[7];
            nf.gt = a > b;
            nf.lt = a < b;
            nf.eq = a == b;
            nf.ne = a != b;
            case (int'(w.condition))
                0: hit = 1'b1;
                1: hit = fl.c;
                2: hit = fl.z;
                3: hit = fl.o;
                4: hit = fl.n;
                5: hit = fl.gt;
                6: hit = fl.lt;
                7: hit = fl.eq;
                default: hit = fl.ne;
            endcase
            if (hit != w.cond_inv) begin
                if (w.set_flags) begin
                    fl = nf;
                end
                case (int'(w.targ_dev))
                    0, 1, 2, 3: r[int'(w.targ_dev)] = res;
                    4: marlo = res;
                    5: marhi = res;
                    6: ram[addr] = res;
                    7: exp_uart.push_back(res);
                    9: pc = int'(res);
                    10: begin
                        exp_halt = res;
                        done = 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    endtask

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_uart(input int t, input int idx, input cpu_alu_pkg::word_t exp,
            input cpu_alu_pkg::word_t act);
        if (act !== exp) begin
            $display("FAIL test %0d uart byte %0d expected %02h actual %02h", t, idx, exp, act);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_halt(input int t, input cpu_alu_pkg::word_t exp,
            input cpu_alu_pkg::word_t act);
        if (act !== exp) begin
            $display("FAIL test %0d halt code expected %02h actual %02h", t, exp, act);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic report_problem(input int t, input string what);
        $display("test %0d: %s", t, what);
        errors++;
        test_bad = 1'b1;
    endtask

    ////////////////////////////////////////
    // per-test sequence
    ////////////////////////////////////////

    task automatic run_test(input int t);
        int cycles;
        test_bad = 1'b0;
        tests_run++;
        build_program();
        run_model();
        got_uart.delete();
        @(posedge CPU);
        _RESET_SWITCH <= 1'b1;
        repeat (2) @(posedge CPU);
        for (int i = 0; i < prog_len + 3; i++) begin
            if (i < prog_len) begin
                prog_we   <= 1'b1;
                prog_addr <= i[7:0];
                prog_data <= prog[i];
            end else begin
                prog_we <= 1'b0;
            end
            @(negedge CPU);
            if (uart_valid !== 1'b0 || halted !== 1'b0) begin
                report_problem(t, "uart_valid or halted not low while reset is held");
            end
            @(posedge CPU);
        end
        _RESET_SWITCH <= 1'b0;
        cycles = 0;
        while (halted !== 1'b1 && cycles < 2000) begin
            @(negedge CPU);
            if (uart_valid === 1'b1) begin
                got_uart.push_back(uart_data);
            end
            cycles++;
        end
        if (halted !== 1'b1) begin
            report_problem(t, "core did not halt within 2000 cycles");
            tests_failed++;
            timed_out = 1'b1;
            return;
        end
        for (int k = 0; k < 5; k++) begin
            @(negedge CPU);
            if (uart_valid !== 1'b0) begin
                report_problem(t, "uart byte appeared after halted");
            end
        end
        if (got_uart.size() != exp_uart.size()) begin
            report_problem(t, $sformatf("got %0d uart bytes but expected %0d",
                got_uart.size(), exp_uart.size()));
        end
        for (int k = 0; k < got_uart.size() && k < exp_uart.size(); k++) begin
            check_uart(t, k, exp_uart[k], got_uart[k]);
        end
        check_halt(t, exp_halt, halt_code);
        if (test_bad) begin
            tests_failed++;
        end
        $display("test %0d (%0d instructions, %0d uart bytes): %s", t, prog_len,
            exp_uart.size(), test_bad ? "failed" : "passed");
    endtask

    initial begin
        CPU           = 1'b0;
        _RESET_SWITCH = 1'b1;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        lfsr_state    = 32'h8ccb_d88c;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        timed_out     = 1'b0;
        repeat (3) @(posedge CPU);
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            run_test(t);
        end
        $display("tests run %0d, failed %0d, check errors %0d", tests_run,
            tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/cpu_properties.sv
// CPU port assertions
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
    input wire logic CPU,
    input wire logic _RESET_SWITCH,
    input wire logic prog_we,
    input wire logic uart_valid,
    input wire logic halted
);

    // reset clears the uart strobe
    a_uart_low_after_reset: assert property (@(posedge CPU) _RESET_SWITCH |=> !uart_valid)
        else $error("uart_valid high in the cycle after reset");

    a_halt_sticky: assert property (@(posedge CPU) disable iff (_RESET_SWITCH)
        halted |=> halted)
        else $error("halted fell without reset");

    a_no_uart_when_halted: assert property (@(posedge CPU) disable iff (_RESET_SWITCH)
        !(uart_valid && halted))
        else $error("uart_valid high while halted");

    // loader only active under reset
    a_load_in_reset: assert property (@(posedge CPU) !_RESET_SWITCH |-> !prog_we)
        else $error("prog_we high while reset is low");

endmodule

bind cpu_top cpu_properties u_props (
    .CPU(CPU),
    ._RESET_SWITCH(_RESET_SWITCH),
    .prog_we(prog_we),
    .uart_valid(uart_valid),
    .halted(halted)
);

`default_nettype wire

//--- source/cpu_top.sv
// microcoded CPU core
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int PROG_ADDR_W = 8,
    parameter int RAM_ADDR_W  = 6
) (
    input  wire logic                   CPU,
    input  wire logic                   _RESET_SWITCH,
    input  wire logic                   prog_we,
    input  wire logic [PROG_ADDR_W-1:0] prog_addr,
    input  wire cpu_isa_pkg::instr_t    prog_data,
    output logic                        uart_valid,
    output cpu_alu_pkg::word_t          uart_data,
    output logic                        halted,
    output cpu_alu_pkg::word_t          halt_code
);

    cpu_isa_pkg::ctl_t       ctl;
    logic                    exec_en;
    cpu_alu_pkg::word_t      result;
    cpu_alu_pkg::word_pair_t mar;
    cpu_alu_pkg::word_t      ram_rd;
    logic                    jump;
    cpu_alu_pkg::word_pair_t jump_addr;
    logic                    halt_req;

    // sequencer keeps its own halted copy to freeze the pc
    program_sequencer #(.PROG_ADDR_W(PROG_ADDR_W)) u_seq (
        .CPU(CPU), ._RESET_SWITCH(_RESET_SWITCH),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .jump(jump), .jump_addr(jump_addr), .halt_req(halt_req),
        .ctl(ctl), .halted()
    );

    alu_datapath u_alu (
        .CPU(CPU), ._RESET_SWITCH(_RESET_SWITCH), .ctl(ctl),
        .mar(mar), .ram_rd(ram_rd), .exec_en(exec_en), .result(result)
    );

    target_writeback #(.RAM_ADDR_W(RAM_ADDR_W)) u_wb (
        .CPU(CPU), ._RESET_SWITCH(_RESET_SWITCH), .ctl(ctl),
        .exec_en(exec_en), .result(result), .mar(mar), .ram_rd(ram_rd),
        .jump(jump), .jump_addr(jump_addr), .halt_req(halt_req),
        .uart_valid(uart_valid), .uart_data(uart_data),
        .halted(halted), .halt_code(halt_code)
    );

endmodule

`default_nettype wire

//--- source/target_writeback.sv
// non-register target writes
`timescale 1ns/1ps
`default_nettype none

module target_writeback #(
    parameter int RAM_ADDR_W = 6
) (
    input  wire logic               CPU,
    input  wire logic               _RESET_SWITCH,
    input  wire cpu_isa_pkg::ctl_t  ctl,
    input  wire logic               exec_en,
    input  wire cpu_alu_pkg::word_t result,
    output cpu_alu_pkg::word_pair_t mar,
    output cpu_alu_pkg::word_t      ram_rd,
    output logic                    jump,
    output cpu_alu_pkg::word_pair_t jump_addr,
    output logic                    halt_req,
    output logic                    uart_valid,
    output cpu_alu_pkg::word_t      uart_data,
    output logic                    halted,
    output cpu_alu_pkg::word_t      halt_code
);

    cpu_alu_pkg::word_t ram [2**RAM_ADDR_W];

    cpu_alu_pkg::word_pair_t addr16;
    logic [RAM_ADDR_W-1:0]   ram_addr;
    cpu_alu_pkg::word_t      pchitmp_q;

    ////////////////////////////////////////
    // RAM addressing
    ////////////////////////////////////////

    // direct mode takes the address from the operand
    assign addr16   = ctl.addr_direct ? ctl.operand.direct_addr : mar;
    assign ram_addr = addr16[RAM_ADDR_W-1:0];
    assign ram_rd   = ram[ram_addr];

    // MAR halves and RAM
    always_ff @(posedge CPU) begin
        if (exec_en) begin
            case (ctl.targ_dev)
                cpu_isa_pkg::tdev_marlo: mar.lo <= result;
                cpu_isa_pkg::tdev_marhi: mar.hi <= result;
                cpu_isa_pkg::tdev_ram:   ram[ram_addr] <= result;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // jump and halt
    ////////////////////////////////////////

    always_ff @(posedge CPU) begin
        if (_RESET_SWITCH) begin
            pchitmp_q <= '0;
        end else if (exec_en && ctl.targ_dev == cpu_isa_pkg::tdev_pchitmp) begin
            pchitmp_q <= result;
        end
    end

    assign jump      = exec_en && ctl.targ_dev == cpu_isa_pkg::tdev_pc;
    assign jump_addr = {pchitmp_q, result};
    assign halt_req  = exec_en && ctl.targ_dev == cpu_isa_pkg::tdev_halt;

    always_ff @(posedge CPU) begin
        if (_RESET_SWITCH) begin
            halted <= 1'b0;
        end else if (halt_req) begin
            halted <= 1'b1;
        end
    end

    always_ff @(posedge CPU) begin
        if (halt_req) begin
            halt_code <= result;
        end
    end

    ////////////////////////////////////////
    // UART output
    ////////////////////////////////////////

    // one-cycle strobe after the writing edge
    always_ff @(posedge CPU) begin
        if (_RESET_SWITCH) begin
            uart_valid <= 1'b0;
        end else begin
            uart_valid <= exec_en && ctl.targ_dev == cpu_isa_pkg::tdev_uart;
        end
    end

    always_ff @(posedge CPU) begin
        if (exec_en && ctl.targ_dev == cpu_isa_pkg::tdev_uart) begin
            uart_data <= result;
        end
    end

endmodule

`default_nettype wire

//--- source/alu_datapath.sv
// register file, ALU and flags
`timescale 1ns/1ps
`default_nettype none

module alu_datapath (
    input  wire logic                    CPU,
    input  wire logic                    _RESET_SWITCH,
    input  wire cpu_isa_pkg::ctl_t       ctl,
    input  wire cpu_alu_pkg::word_pair_t mar,
    input  wire cpu_alu_pkg::word_t      ram_rd,
    output logic                         exec_en,
    output cpu_alu_pkg::word_t           result
);

    cpu_alu_pkg::word_t regs [4];

    cpu_alu_pkg::word_t a_bus;
    cpu_alu_pkg::word_t b_bus;
    cpu_alu_pkg::word_t add_x;
    cpu_alu_pkg::word_t add_y;
    logic               add_cin;
    logic               arith;
    logic [8:0]         sum;
    cpu_alu_pkg::flags_t alu_flags;
    cpu_alu_pkg::flags_t flags_q;
    logic               cond_hit;

    ////////////////////////////////////////
    // bus selection
    ////////////////////////////////////////

    always_comb begin
        case (ctl.adev)
            cpu_isa_pkg::adev_rega: a_bus = regs[0];
            cpu_isa_pkg::adev_regb: a_bus = regs[1];
            cpu_isa_pkg::adev_regc: a_bus = regs[2];
            cpu_isa_pkg::adev_regd: a_bus = regs[3];
            default:                a_bus = '0;
        endcase
    end

    always_comb begin
        case (ctl.bdev)
            cpu_isa_pkg::bdev_rega:  b_bus = regs[0];
            cpu_isa_pkg::bdev_regb:  b_bus = regs[1];
            cpu_isa_pkg::bdev_regc:  b_bus = regs[2];
            cpu_isa_pkg::bdev_regd:  b_bus = regs[3];
            cpu_isa_pkg::bdev_immed: b_bus = ctl.operand.imm.immed;
            cpu_isa_pkg::bdev_ram:   b_bus = ram_rd;
            cpu_isa_pkg::bdev_marlo: b_bus = mar.lo;
            cpu_isa_pkg::bdev_marhi: b_bus = mar.hi;
            default:                 b_bus = '0;
        endcase
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    // one shared adder, subtract is a + ~b + 1 so c set means no borrow
    always_comb begin
        add_x   = a_bus;
        add_y   = b_bus;
        add_cin = 1'b0;
        arith   = 1'b0;
        result  = '0;
        case (ctl.alu_op)
            cpu_alu_pkg::op_a:        result = a_bus;
            cpu_alu_pkg::op_b:        result = b_bus;
            cpu_alu_pkg::op_b_plus_1: begin
                add_x   = b_bus;
                add_y   = '0;
                add_cin = 1'b1;
                arith   = 1'b1;
            end
            cpu_alu_pkg::op_a_plus_b: arith = 1'b1;
            cpu_alu_pkg::op_a_plus_b_plus_c: begin
                add_cin = flags_q.c;
                arith   = 1'b1;
            end
            cpu_alu_pkg::op_a_minus_b: begin
                add_y   = ~b_bus;
                add_cin = 1'b1;
                arith   = 1'b1;
            end
            cpu_alu_pkg::op_a_and_b:  result = a_bus & b_bus;
            cpu_alu_pkg::op_a_or_b:   result = a_bus | b_bus;
            cpu_alu_pkg::op_a_xor_b:  result = a_bus ^ b_bus;
            cpu_alu_pkg::op_not_b:    result = ~b_bus;
            default:                  result = '0;
        endcase
        sum = {1'b0, add_x} + {1'b0, add_y} + {8'd0, add_cin};
        if (arith) begin
            result = sum[7:0];
        end
    end

    always_comb begin
        alu_flags.c  = arith & sum[8];
        // signed overflow: like signs in, different sign out
        alu_flags.o  = arith & (add_x[7] == add_y[7]) & (sum[7] != add_x[7]);
        alu_flags.z  = (result == '0);
        alu_flags.n  = result[7];
        alu_flags.gt = (a_bus > b_bus);
        alu_flags.lt = (a_bus < b_bus);
        alu_flags.eq = (a_bus == b_bus);
        alu_flags.ne = (a_bus != b_bus);
    end

    ////////////////////////////////////////
    // condition and flags
    ////////////////////////////////////////

    always_comb begin
        case (ctl.condition)
            cpu_isa_pkg::cond_a:  cond_hit = 1'b1;
            cpu_isa_pkg::cond_c:  cond_hit = flags_q.c;
            cpu_isa_pkg::cond_z:  cond_hit = flags_q.z;
            cpu_isa_pkg::cond_o:  cond_hit = flags_q.o;
            cpu_isa_pkg::cond_n:  cond_hit = flags_q.n;
            cpu_isa_pkg::cond_gt: cond_hit = flags_q.gt;
            cpu_isa_pkg::cond_lt: cond_hit = flags_q.lt;
            cpu_isa_pkg::cond_eq: cond_hit = flags_q.eq;
            cpu_isa_pkg::cond_ne: cond_hit = flags_q.ne;
            default:              cond_hit = 1'b0;
        endcase
    end

    assign exec_en = ctl.valid & (cond_hit ^ ctl.cond_inv);

    always_ff @(posedge CPU) begin
        if (_RESET_SWITCH) begin
            flags_q <= '0;
        end else if (exec_en && ctl.set_flags) begin
            flags_q <= alu_flags;
        end
    end

    // register targets share their low code bits with the index
    always_ff @(posedge CPU) begin
        if (exec_en && ctl.targ_dev <= cpu_isa_pkg::tdev_regd) begin
            regs[ctl.targ_dev[1:0]] <= result;
        end
    end

endmodule

`default_nettype wire

//--- source/program_sequencer.sv
// instruction fetch and sequencing
`timescale 1ns/1ps
`default_nettype none

module program_sequencer #(
    parameter int PROG_ADDR_W = 8
) (
    input  wire logic                    CPU,
    input  wire logic                    _RESET_SWITCH,
    input  wire logic                    prog_we,
    input  wire logic [PROG_ADDR_W-1:0]  prog_addr,
    input  wire cpu_isa_pkg::instr_t     prog_data,
    input  wire logic                    jump,
    input  wire cpu_alu_pkg::word_pair_t jump_addr,
    input  wire logic                    halt_req,
    output cpu_isa_pkg::ctl_t            ctl,
    output logic                         halted
);

    cpu_isa_pkg::instr_t imem [2**PROG_ADDR_W];

    logic [PROG_ADDR_W-1:0] pc;
    cpu_isa_pkg::instr_t    fetch_q;
    logic                   valid_q;

    ////////////////////////////////////////
    // program load
    ////////////////////////////////////////

    // loader only writes while the core is held in reset
    always_ff @(posedge CPU) begin
        if (_RESET_SWITCH && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    ////////////////////////////////////////
    // fetch
    ////////////////////////////////////////

    always_ff @(posedge CPU) begin
        fetch_q <= imem[pc];
    end

    always_ff @(posedge CPU) begin
        if (_RESET_SWITCH) begin
            pc      <= '0;
            valid_q <= 1'b0;
            halted  <= 1'b0;
        end else if (halted || halt_req) begin
            // pc frozen, pipeline drained for good
            valid_q <= 1'b0;
            halted  <= 1'b1;
        end else if (jump) begin
            // drop the word fetched behind the jump
            pc      <= jump_addr[PROG_ADDR_W-1:0];
            valid_q <= 1'b0;
        end else begin
            pc      <= pc + 1'b1;
            valid_q <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // field decode
    ////////////////////////////////////////

    always_comb begin
        ctl.valid       = valid_q;
        ctl.alu_op      = fetch_q.alu_op;
        ctl.targ_dev    = fetch_q.targ_dev;
        ctl.adev        = fetch_q.adev;
        ctl.bdev        = fetch_q.bdev;
        ctl.condition   = fetch_q.condition;
        ctl.set_flags   = fetch_q.set_flags;
        ctl.cond_inv    = fetch_q.cond_inv;
        ctl.addr_direct = fetch_q.addr_direct;
        ctl.operand     = fetch_q.operand;
    end

endmodule

`default_nettype wire

//--- source/cpu_isa_pkg.sv
// microcode instruction format
`default_nettype none

package cpu_isa_pkg;

    // write target of an instruction
    typedef enum logic [4:0] {
        tdev_rega     = 5'd0,
        tdev_regb     = 5'd1,
        tdev_regc     = 5'd2,
        tdev_regd     = 5'd3,
        tdev_marlo    = 5'd4,
        tdev_marhi    = 5'd5,
        tdev_ram      = 5'd6,
        tdev_uart     = 5'd7,
        tdev_pchitmp  = 5'd8,
        tdev_pc       = 5'd9,
        tdev_halt     = 5'd10,
        tdev_not_used = 5'd11
    } targ_dev_e;

    // A bus sources, not_used reads as zero
    typedef enum logic [3:0] {
        adev_rega     = 4'd0,
        adev_regb     = 4'd1,
        adev_regc     = 4'd2,
        adev_regd     = 4'd3,
        adev_not_used = 4'd4
    } adev_e;

    // B bus sources
    typedef enum logic [3:0] {
        bdev_rega  = 4'd0,
        bdev_regb  = 4'd1,
        bdev_regc  = 4'd2,
        bdev_regd  = 4'd3,
        bdev_immed = 4'd4,
        bdev_ram   = 4'd5,
        bdev_marlo = 4'd6,
        bdev_marhi = 4'd7
    } bdev_e;

    // execute condition, tested against stored flags
    typedef enum logic [3:0] {
        cond_a  = 4'd0,
        cond_c  = 4'd1,
        cond_z  = 4'd2,
        cond_o  = 4'd3,
        cond_n  = 4'd4,
        cond_gt = 4'd5,
        cond_lt = 4'd6,
        cond_eq = 4'd7,
        cond_ne = 4'd8
    } cond_e;

    // immediate view of the operand
    typedef struct packed {
        cpu_alu_pkg::word_t unused_hi;
        cpu_alu_pkg::word_t immed;
    } imm_t;

    // operand is either a direct address or an immediate byte
    typedef union packed {
        cpu_alu_pkg::word_pair_t direct_addr;
        imm_t                    imm;
    } operand_u;

    // 48-bit horizontal control word
    typedef struct packed {
        cpu_alu_pkg::alu_op_e alu_op;
        targ_dev_e            targ_dev;
        adev_e                adev;
        bdev_e                bdev;
        cond_e                condition;
        logic                 set_flags;
        logic                 cond_inv;
        logic                 addr_direct;
        logic [6:0]           pad;
        operand_u             operand;
    } instr_t;

    // decoded word in the execute stage
    typedef struct packed {
        logic                 valid;
        cpu_alu_pkg::alu_op_e alu_op;
        targ_dev_e            targ_dev;
        adev_e                adev;
        bdev_e                bdev;
        cond_e                condition;
        logic                 set_flags;
        logic                 cond_inv;
        logic                 addr_direct;
        operand_u             operand;
    } ctl_t;

endpackage

`default_nettype wire

//--- source/cpu_alu_pkg.sv
// ALU data types and operations
`default_nettype none

package cpu_alu_pkg;

    // one data byte
    typedef logic [7:0] word_t;

    // two bytes forming a 16-bit address
    typedef struct packed {
        word_t hi;
        word_t lo;
    } word_pair_t;

    // 5-bit ALU operation, unused codes give zero
    typedef enum logic [4:0] {
        op_a               = 5'd0,
        op_b               = 5'd1,
        op_b_plus_1        = 5'd2,
        op_a_plus_b        = 5'd3,
        op_a_plus_b_plus_c = 5'd4,
        op_a_minus_b       = 5'd5,
        op_a_and_b         = 5'd6,
        op_a_or_b          = 5'd7,
        op_a_xor_b         = 5'd8,
        op_not_b           = 5'd9,
        op_zero            = 5'd10
    } alu_op_e;

    // status flags, c is the top bit
    typedef struct packed {
        logic c;
        logic z;
        logic o;
        logic n;
        logic gt;
        logic lt;
        logic eq;
        logic ne;
    } flags_t;

endpackage

`default_nettype wire
